//--- common/mipsPkg.sv
`default_nettype none
`include "mips_settings.svh"

package mipsPkg;

  //////////////////////////////
  // vector types
  //////////////////////////////
  typedef logic [31:0] instWord;                           // raw instruction from host
  typedef logic [`MIPS_DATA_W-1:0] dataWord;               // register / memory value
  typedef logic [$clog2(`MIPS_REG_N)-1:0] regIdx;          // register number
  typedef logic [5:0] opcode;                              // inst[31:26]
  typedef logic [5:0] funct;                               // inst[5:0] of R-type words
  typedef logic [3:0] aluOpCode;                           // controller to ALU

  // ALU op encoding
  localparam aluOpCode aluAddr   = 4'b0000;  // load/store address
  localparam aluOpCode aluAddImm = 4'b0001;
  localparam aluOpCode aluUseFn  = 4'b0010;  // R-type picks the op by funct
  localparam aluOpCode aluAnd    = 4'b1010;
  localparam aluOpCode aluOr     = 4'b1011;
  localparam aluOpCode aluXor    = 4'b1100;
  localparam aluOpCode aluSlt    = 4'b1101;

  // opcodes
  localparam opcode opR    = 6'b000000;
  localparam opcode opAddi = 6'b001000;
  localparam opcode opSlti = 6'b001010;
  localparam opcode opAndi = 6'b001100;
  localparam opcode opOri  = 6'b001101;
  localparam opcode opXori = 6'b001110;
  localparam opcode opLb   = 6'b100000;
  localparam opcode opLh   = 6'b100001;
  localparam opcode opLw   = 6'b100011;
  localparam opcode opSb   = 6'b101000;
  localparam opcode opSh   = 6'b101001;
  localparam opcode opSw   = 6'b101011;

  // R-type funct codes
  localparam funct fnAdd = 6'b100000;
  localparam funct fnSub = 6'b100010;
  localparam funct fnAnd = 6'b100100;
  localparam funct fnOr  = 6'b100101;
  localparam funct fnXor = 6'b100110;
  localparam funct fnSlt = 6'b101010;

  //////////////////////////////
  // enums
  //////////////////////////////
  typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} memSize;
  typedef enum logic [1:0] {kindNone, kindRegWrite, kindMemWrite} commitKind;
  typedef enum logic [1:0] {stIdle, stExecute, stAccess, stReport} coreState;

endpackage

`default_nettype wire

//--- common/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

//////////////////////////////
// datapath sizing
//////////////////////////////
`define MIPS_DATA_W 32     // register and memory word
`define MIPS_REG_N 32      // architectural registers, r0 hardwired
`define MIPS_MEM_WORDS 64  // data memory, word index from addr[7:2]

//////////////////////////////
// testbench
//////////////////////////////
`define MIPS_TB_CYCLES_PER_ITEM 40  // timeout budget per golden item

`endif

//--- core/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
  input  wire mipsPkg::aluOpCode aluOp,
  input  wire mipsPkg::funct     fn,
  input  wire mipsPkg::dataWord  a,
  input  wire mipsPkg::dataWord  b,
  output mipsPkg::dataWord       result
);

  logic lessThan;  // signed compare for slt / slti

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      mipsPkg::aluAddr,
      mipsPkg::aluAddImm: result = a + b;
      mipsPkg::aluAnd:    result = a & b;
      mipsPkg::aluOr:     result = a | b;
      mipsPkg::aluXor:    result = a ^ b;
      mipsPkg::aluSlt:    result = mipsPkg::dataWord'(lessThan);
      mipsPkg::aluUseFn: begin
        // R-type, funct picks the operation
        case (fn)
          mipsPkg::fnAdd: result = a + b;
          mipsPkg::fnSub: result = a - b;
          mipsPkg::fnAnd: result = a & b;
          mipsPkg::fnOr:  result = a | b;
          mipsPkg::fnXor: result = a ^ b;
          mipsPkg::fnSlt: result = mipsPkg::dataWord'(lessThan);
          default:        result = '0;  // unsupported funct
        endcase
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- core/execCore.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_settings.svh"

module execCore (
  input  wire logic             clk,
  input  wire logic             rstN,
  input  wire logic             wordValid,
  input  wire mipsPkg::instWord wordData,
  output logic                  wordTaken,
  input  wire logic             portBusy,
  output logic                  recValid,
  output mipsPkg::commitKind    recKind,
  output mipsPkg::regIdx        recDest,
  output mipsPkg::dataWord      recValue,
  output mipsPkg::dataWord      recAddr   // byte address of loads and stores only
);

  localparam int MemAw = $clog2(`MIPS_MEM_WORDS);  // word index bits
  localparam int DataW = `MIPS_DATA_W;

  mipsPkg::coreState state;
  mipsPkg::instWord  inst;       // word in flight
  mipsPkg::dataWord  aluRes;     // result or effective address
  mipsPkg::dataWord  storeData;  // rt as read in execute

  // decoded controls
  logic              regDst;
  logic              memRead;
  logic              memToReg;
  logic              memWrite;
  logic              aluSrc;
  logic              regWrite;
  mipsPkg::aluOpCode aluOp;
  mipsPkg::memSize   size;

  mipsPkg::regIdx   rs;
  mipsPkg::regIdx   rt;
  mipsPkg::regIdx   rd;
  mipsPkg::regIdx   dest;
  mipsPkg::dataWord rsVal;
  mipsPkg::dataWord rtVal;
  mipsPkg::dataWord immExt;
  mipsPkg::dataWord aluB;
  mipsPkg::dataWord aluOut;
  logic             zeroExt;

  mipsPkg::dataWord regFile [`MIPS_REG_N];
  mipsPkg::dataWord dataMem [`MIPS_MEM_WORDS];
  logic [MemAw-1:0] memIdx;
  mipsPkg::dataWord memWord;
  mipsPkg::dataWord loadVal;     // sign-extended load result
  mipsPkg::dataWord mergedWord;  // memory word after a partial store
  mipsPkg::dataWord wbVal;
  logic [15:0]      halfSel;
  logic [7:0]       byteSel;

  //////////////////////////////
  // decode and execute
  //////////////////////////////
  assign rs   = inst[25:21];
  assign rt   = inst[20:16];
  assign rd   = inst[15:11];
  assign dest = regDst ? rd : rt;

  mainController u_mainController (
    .op(inst[31:26]), .regDst(regDst), .memRead(memRead), .memToReg(memToReg),
    .memWrite(memWrite), .aluSrc(aluSrc), .regWrite(regWrite), .aluOp(aluOp), .size(size)
  );

  // andi/ori/xori take the immediate unsigned
  assign zeroExt = (aluOp == mipsPkg::aluAnd) || (aluOp == mipsPkg::aluOr) ||
                   (aluOp == mipsPkg::aluXor);
  assign immExt  = zeroExt ? {{(DataW-16){1'b0}}, inst[15:0]} :
                             {{(DataW-16){inst[15]}}, inst[15:0]};

  assign rsVal = regFile[rs];
  assign rtVal = regFile[rt];
  assign aluB  = aluSrc ? immExt : rtVal;

  aluUnit u_aluUnit (.aluOp(aluOp), .fn(inst[5:0]), .a(rsVal), .b(aluB), .result(aluOut));

  //////////////////////////////
  // memory access
  //////////////////////////////
  assign memIdx  = aluRes[MemAw+1:2];  // word index above the byte offset
  assign memWord = dataMem[memIdx];
  assign halfSel = memWord[{aluRes[1], 4'b0000} +: 16];
  assign byteSel = memWord[{aluRes[1:0], 3'b000} +: 8];

  always_comb begin
    mergedWord = memWord;
    case (size)
      mipsPkg::sizeHalf: begin
        loadVal = {{(DataW-16){halfSel[15]}}, halfSel};
        mergedWord[{aluRes[1], 4'b0000} +: 16] = storeData[15:0];
      end
      mipsPkg::sizeByte: begin
        loadVal = {{(DataW-8){byteSel[7]}}, byteSel};
        mergedWord[{aluRes[1:0], 3'b000} +: 8] = storeData[7:0];
      end
      default: begin
        loadVal    = memWord;
        mergedWord = storeData;  // full word replaces
      end
    endcase
  end

  // r0 reads back as zero so its commit shows 0
  assign wbVal = (dest == '0) ? '0 : (memToReg ? loadVal : aluRes);

  assign wordTaken = (state == mipsPkg::stIdle) && wordValid;
  assign recValid  = (state == mipsPkg::stReport) && !portBusy;

  //////////////////////////////
  // sequencer
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= mipsPkg::stIdle;
      for (int i = 0; i < `MIPS_REG_N; i++) begin
        regFile[i] <= '0;
      end
      for (int j = 0; j < `MIPS_MEM_WORDS; j++) begin
        dataMem[j] <= '0;
      end
    end else begin
      case (state)
        mipsPkg::stIdle: if (wordValid) state <= mipsPkg::stExecute;
        mipsPkg::stExecute: state <= mipsPkg::stAccess;
        mipsPkg::stAccess: begin
          state <= mipsPkg::stReport;
          if (regWrite && dest != '0)
            regFile[dest] <= wbVal;
          if (memWrite)
            dataMem[memIdx] <= mergedWord;  // read-merge-write
        end
        mipsPkg::stReport: if (!portBusy) state <= mipsPkg::stIdle;  // record handed over
        default: state <= mipsPkg::stIdle;
      endcase
    end
  end

  // datapath registers and the commit record
  always_ff @(posedge clk) begin
    case (state)
      mipsPkg::stIdle: if (wordValid) inst <= wordData;
      mipsPkg::stExecute: begin
        aluRes    <= aluOut;
        storeData <= rtVal;
      end
      mipsPkg::stAccess: begin
        if (regWrite) begin
          recKind  <= mipsPkg::kindRegWrite;
          recDest  <= dest;
          recValue <= wbVal;
        end else if (memWrite) begin
          recKind  <= mipsPkg::kindMemWrite;
          recDest  <= '0;
          recValue <= mergedWord;
        end else begin
          recKind  <= mipsPkg::kindNone;  // unknown opcode
          recDest  <= '0;
          recValue <= '0;
        end
        recAddr <= (memRead || memWrite) ? aluRes : '0;
      end
      default: ;
    endcase
  end

  // port must go busy so the next record waits
  recTakenByPort: assert property (@(posedge clk) disable iff (!rstN)
    recValid |=> portBusy)
    else $error("commit port stayed idle after a record was offered");

endmodule

`default_nettype wire

//--- core/mainController.sv
`timescale 1ns/10ps
`default_nettype none

module mainController (
  input  wire mipsPkg::opcode op,
  output logic                regDst,    // rd instead of rt
  output logic                memRead,
  output logic                memToReg,  // writeback from memory
  output logic                memWrite,
  output logic                aluSrc,    // immediate as operand b
  output logic                regWrite,
  output mipsPkg::aluOpCode   aluOp,
  output mipsPkg::memSize     size       // access width for loads/stores
);

  always_comb begin
    // unknown opcode leaves everything off
    regDst   = 1'b0;
    memRead  = 1'b0;
    memToReg = 1'b0;
    memWrite = 1'b0;
    aluSrc   = 1'b0;
    regWrite = 1'b0;
    aluOp    = mipsPkg::aluAddr;

    case (op)
      mipsPkg::opR: begin
        regDst   = 1'b1;
        aluOp    = mipsPkg::aluUseFn;
        regWrite = 1'b1;
      end
      mipsPkg::opAddi, mipsPkg::opAndi, mipsPkg::opOri,
      mipsPkg::opXori, mipsPkg::opSlti: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opLw, mipsPkg::opLh, mipsPkg::opLb: begin
        memRead  = 1'b1;
        memToReg = 1'b1;
        aluSrc   = 1'b1;  // base + offset
        regWrite = 1'b1;
      end
      mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
      end
      default: ;
    endcase

    // immediate ALU ops, loads/stores keep aluAddr
    case (op)
      mipsPkg::opAddi: aluOp = mipsPkg::aluAddImm;
      mipsPkg::opAndi: aluOp = mipsPkg::aluAnd;
      mipsPkg::opOri:  aluOp = mipsPkg::aluOr;
      mipsPkg::opXori: aluOp = mipsPkg::aluXor;
      mipsPkg::opSlti: aluOp = mipsPkg::aluSlt;
      default: ;
    endcase

    case (op)  // access width
      mipsPkg::opLh, mipsPkg::opSh: size = mipsPkg::sizeHalf;
      mipsPkg::opLb, mipsPkg::opSb: size = mipsPkg::sizeByte;
      default:                      size = mipsPkg::sizeWord;
    endcase
  end

  memExclusive: assert final (!(memRead && memWrite))
    else $error("opcode %b decodes to both memory read and write", op);

endmodule

`default_nettype wire

//--- design/commitPort.sv
`timescale 1ns/10ps
`default_nettype none

module commitPort (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              recValid,
  input  wire mipsPkg::commitKind recKind,
  input  wire mipsPkg::regIdx    recDest,
  input  wire mipsPkg::dataWord  recValue,
  input  wire mipsPkg::dataWord  recAddr,
  output logic                   portBusy,  // until ack seen low
  output logic                   commitReq,
  output mipsPkg::commitKind     commitKind,
  output mipsPkg::regIdx         commitDest,
  output mipsPkg::dataWord       commitAddr,
  output mipsPkg::dataWord       commitValue,
  input  wire logic              commitAck
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      commitReq <= 1'b0;
      portBusy  <= 1'b0;
    end else if (recValid) begin
      commitReq <= 1'b1;
      portBusy  <= 1'b1;
    end else if (commitReq && commitAck) begin
      commitReq <= 1'b0;  // host took it
    end else if (portBusy && !commitReq && !commitAck) begin
      portBusy  <= 1'b0;  // handshake back to idle
    end
  end

  // record held for the whole handshake
  always_ff @(posedge clk) begin
    if (recValid) begin
      commitKind  <= recKind;
      commitDest  <= recDest;
      commitAddr  <= recAddr;
      commitValue <= recValue;
    end
  end

  fieldsHeld: assert property (@(posedge clk) disable iff (!rstN)
    commitReq && $past(commitReq) |->
      $stable({commitKind, commitDest, commitAddr, commitValue}))
    else $error("commit record changed while commitReq high");

endmodule

`default_nettype wire

//--- design/instPort.sv
`timescale 1ns/10ps
`default_nettype none

module instPort (
  input  wire logic             clk,
  input  wire logic             rstN,
  input  wire logic             instReq,
  input  wire mipsPkg::instWord instData,
  output logic                  instAck,
  output logic                  wordValid,  // buffer full
  output mipsPkg::instWord      wordData,
  input  wire logic             wordTaken   // core pulse, empties buffer
);

  logic capture;  // new word accepted this edge

  // only when the link is idle and the buffer is free
  assign capture = instReq && !instAck && !wordValid;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      instAck   <= 1'b0;
      wordValid <= 1'b0;
    end else begin
      if (capture) begin
        instAck   <= 1'b1;
        wordValid <= 1'b1;
      end else if (wordTaken) begin
        wordValid <= 1'b0;  // core latched it
      end
      if (instAck && !instReq)
        instAck <= 1'b0;    // second half of the handshake
    end
  end

  // one-entry buffer
  always_ff @(posedge clk) begin
    if (capture)
      wordData <= instData;
  end

  ackAfterReqLow: assert property (@(posedge clk) disable iff (!rstN)
    $fell(instAck) |-> !$past(instReq))
    else $error("instAck dropped before instReq went low");

endmodule

`default_nettype wire

//--- design/mipsSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module mipsSubsystem (
  input  wire logic             clk,
  input  wire logic             rstN,
  input  wire logic             instReq,
  input  wire mipsPkg::instWord instData,
  output logic                  instAck,
  output logic                  commitReq,
  output mipsPkg::commitKind    commitKind,
  output mipsPkg::regIdx        commitDest,
  output mipsPkg::dataWord      commitAddr,
  output mipsPkg::dataWord      commitValue,
  input  wire logic             commitAck
);

  // instPort to execCore
  logic              wordValid;
  mipsPkg::instWord  wordData;
  logic              wordTaken;
  // execCore to commitPort
  logic              recValid;
  mipsPkg::commitKind recKind;
  mipsPkg::regIdx    recDest;
  mipsPkg::dataWord  recValue;
  mipsPkg::dataWord  recAddr;
  logic              portBusy;

  instPort u_instPort (
    .clk(clk), .rstN(rstN), .instReq(instReq), .instData(instData), .instAck(instAck),
    .wordValid(wordValid), .wordData(wordData), .wordTaken(wordTaken)
  );

  execCore u_execCore (
    .clk(clk), .rstN(rstN), .wordValid(wordValid), .wordData(wordData),
    .wordTaken(wordTaken), .portBusy(portBusy), .recValid(recValid), .recKind(recKind),
    .recDest(recDest), .recValue(recValue), .recAddr(recAddr)
  );

  commitPort u_commitPort (
    .clk(clk), .rstN(rstN), .recValid(recValid), .recKind(recKind), .recDest(recDest),
    .recValue(recValue), .recAddr(recAddr), .portBusy(portBusy), .commitReq(commitReq),
    .commitKind(commitKind), .commitDest(commitDest), .commitAddr(commitAddr),
    .commitValue(commitValue), .commitAck(commitAck)
  );

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/mipsPkg.sv
design/instPort.sv
core/mainController.sv
core/aluUnit.sv
core/execCore.sv
design/commitPort.sv
design/mipsSubsystem.sv
verif/commitChecker.sv
verif/tbMipsSubsystem.sv

//--- verif/commitChecker.sv
`timescale 1ns/10ps
`default_nettype none

module commitChecker (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               commitReq,
  input  wire mipsPkg::commitKind commitKind,
  input  wire mipsPkg::regIdx     commitDest,
  input  wire mipsPkg::dataWord   commitAddr,
  input  wire mipsPkg::dataWord   commitValue,
  output int                      checkedCount,   // records compared so far
  output int                      mismatchCount,  // wrong fields
  output int                      extraCount,     // records nobody expected
  output int                      pendingCount    // expected but not yet seen
);

  // expected records, program order
  logic [1:0]       expKind  [$];
  mipsPkg::regIdx   expDest  [$];
  mipsPkg::dataWord expAddr  [$];
  mipsPkg::dataWord expValue [$];
  logic             reqSeen;  // commitReq one edge ago

  task automatic pushExpected(input logic [1:0] kind, input mipsPkg::regIdx dest,
                              input mipsPkg::dataWord addr, input mipsPkg::dataWord value);
    expKind.push_back(kind);
    expDest.push_back(dest);
    expAddr.push_back(addr);
    expValue.push_back(value);
    pendingCount = expKind.size();
  endtask

  task automatic compareField(input string name, input logic [31:0] expected,
                              input logic [31:0] got);
    if (got !== expected) begin
      mismatchCount++;
      $display("mismatch at %0t: record %0d field %s expected %h got %h",
               $time, checkedCount, name, expected, got);
    end
  endtask

  //////////////////////////////
  // compare on the commitReq rise
  //////////////////////////////
  always @(posedge clk) begin
    if (!rstN) begin
      reqSeen <= 1'b0;
    end else begin
      reqSeen <= commitReq;
      if (commitReq && !reqSeen) begin
        if (expKind.size() == 0) begin
          extraCount++;  // nothing left to match
          $display("error at %0t: a commit record arrived after all expected ones", $time);
        end else begin
          compareField("kind", expKind[0], commitKind);
          compareField("dest", expDest[0], commitDest);
          compareField("addr", expAddr[0], commitAddr);
          compareField("value", expValue[0], commitValue);
          void'(expKind.pop_front());
          void'(expDest.pop_front());
          void'(expAddr.pop_front());
          void'(expValue.pop_front());
          pendingCount = expKind.size();
          checkedCount++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/golden_program.txt
# I <instruction word, hex>
# C <kind 0 none, 1 regWrite, 2 memWrite> <dest> <byte addr> <value>, all hex
I 2001FFFB
C 1 01 00000000 FFFFFFFB
I 34028001
C 1 02 00000000 00008001
I 3023F0F0
C 1 03 00000000 0000F0F0
I 3844FFFF
C 1 04 00000000 00007FFE
I 2825FFFF
C 1 05 00000000 00000001
I 20200007
C 1 00 00000000 00000000
I 00443020
C 1 06 00000000 0000FFFF
I 00613822
C 1 07 00000000 0000F0F5
I 00C34024
C 1 08 00000000 0000F0F0
I 00224825
C 1 09 00000000 FFFFFFFB
I 00265026
C 1 0A 00000000 FFFF0004
I 0024582A
C 1 0B 00000000 00000001
I AC0A0008
C 2 00 00000008 FFFF0004
I A402000A
C 2 00 0000000A 80010004
I A0010009
C 2 00 00000009 8001FB04
I 8C0C0008
C 1 0C 00000008 8001FB04
I 840D000A
C 1 0D 0000000A FFFF8001
I 800E0009
C 1 0E 00000009 FFFFFFFB
I FC0F0008
C 0 00 00000000 00000000
I 8C0F0008
C 1 0F 00000008 8001FB04

//--- verif/tbMipsSubsystem.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_settings.svh"

module tbMipsSubsystem;

  logic               clk = 1'b0;
  logic               rstN;
  logic               instReq;
  mipsPkg::instWord   instData;
  logic               instAck;
  logic               commitReq;
  mipsPkg::commitKind commitKind;
  mipsPkg::regIdx     commitDest;
  mipsPkg::dataWord   commitAddr;
  mipsPkg::dataWord   commitValue;
  logic               commitAck;

  mipsPkg::instWord instList [$];  // words from the golden file
  int gapSeed    = 32'h8388;       // instReq gaps
  int ackSeed    = 32'h8388;       // commitAck delays
  int cycleCount = 0;
  int cycleLimit = 0;              // known once the file is read
  int fileErrors = 0;
  int checkedCount;
  int mismatchCount;
  int extraCount;
  int pendingCount;

  always #2 clk = ~clk;  // 4 ns period

  mipsSubsystem u_mipsSubsystem (
    .clk(clk), .rstN(rstN), .instReq(instReq), .instData(instData), .instAck(instAck),
    .commitReq(commitReq), .commitKind(commitKind), .commitDest(commitDest),
    .commitAddr(commitAddr), .commitValue(commitValue), .commitAck(commitAck)
  );

  commitChecker u_commitChecker (
    .clk(clk), .rstN(rstN), .commitReq(commitReq), .commitKind(commitKind),
    .commitDest(commitDest), .commitAddr(commitAddr), .commitValue(commitValue),
    .checkedCount(checkedCount), .mismatchCount(mismatchCount),
    .extraCount(extraCount), .pendingCount(pendingCount)
  );

  //////////////////////////////
  // golden file and host driver
  //////////////////////////////
  task automatic readGolden();
    int               fd;
    string            line;
    mipsPkg::instWord word;
    logic [1:0]       kind;
    mipsPkg::regIdx   dest;
    mipsPkg::dataWord addr;
    mipsPkg::dataWord value;
    fd = $fopen("verif/golden_program.txt", "r");
    if (fd == 0) begin
      fileErrors++;
      $display("error: cannot open verif/golden_program.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;  // blank or comment
      if (line[0] == "I") begin
        void'($sscanf(line, "I %h", word));
        instList.push_back(word);
      end else if (line[0] == "C") begin
        void'($sscanf(line, "C %h %h %h %h", kind, dest, addr, value));
        u_commitChecker.pushExpected(kind, dest, addr, value);
      end else begin
        fileErrors++;
        $display("error: golden file line not understood: %s", line);
      end
    end
    $fclose(fd);
    if (pendingCount != instList.size()) begin
      fileErrors++;  // every word needs one record
      $display("error: golden file has %0d words but %0d expected records",
               instList.size(), pendingCount);
    end
  endtask

  task automatic sendWord(input mipsPkg::instWord word);
    int gap;
    gap = $unsigned($random(gapSeed)) % 4;
    repeat (gap) @(posedge clk);
    instReq  <= 1'b1;
    instData <= word;
    @(posedge clk);
    while (!instAck) @(posedge clk);  // stalls while the core is busy
    instReq <= 1'b0;
    @(posedge clk);
    while (instAck) @(posedge clk);
  endtask

  // commit side acknowledger, random delay per record
  initial begin : ackDriver
    int delay;
    forever begin
      @(posedge clk);
      if (commitReq && !commitAck) begin
        delay = $unsigned($random(ackSeed)) % 5;
        repeat (delay) @(posedge clk);
        commitAck <= 1'b1;
        @(posedge clk);
        while (commitReq) @(posedge clk);
        commitAck <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles: commits stopped arriving, %0d of %0d checked",
               cycleCount, checkedCount, instList.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    rstN      = 1'b0;
    instReq   = 1'b0;
    instData  = '0;
    commitAck = 1'b0;
    readGolden();
    cycleLimit = instList.size() * `MIPS_TB_CYCLES_PER_ITEM + 100;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    foreach (instList[i]) sendWord(instList[i]);
    while (checkedCount + extraCount < instList.size()) @(posedge clk);
    repeat (20) @(posedge clk);  // let a stray record show up
    if (pendingCount != 0)
      $display("error: %0d expected commit records never arrived", pendingCount);
    $display("%0d records checked, %0d mismatches, %0d extra, %0d missing, %0d file errors",
             checkedCount, mismatchCount, extraCount, pendingCount, fileErrors);
    if (mismatchCount + extraCount + pendingCount + fileErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
